/* fb_defines.svh */
// Shared widths, SRAM command bytes and burst limits of the quad-SPI frame reader
`ifndef FB_DEFINES_SVH
`define FB_DEFINES_SVH

// ------------------------------------------------------------
// Data path and host bus widths
// ------------------------------------------------------------
`define FB_DATA_W        32       // Buffer and bus word width
`define FB_ADDR_W        9        // Word address inside one bank
`define FB_WB_ADR_W      11       // Host word address width

// ------------------------------------------------------------
// Quad-SPI SRAM protocol
// ------------------------------------------------------------
`define QSPI_ADDR_W      24       // SRAM byte address width
`define QSPI_CMD_RSTEN   8'h66    // Reset enable
`define QSPI_CMD_RST     8'h99    // Reset
`define QSPI_CMD_READ    8'hEB    // Quad read
`define QSPI_WAIT_CYC    6        // Dummy cycles before read data
`define QSPI_BURST_WORDS 128      // 32-bit words per 512-byte burst

`endif

/* wb_pkg.sv */
// Host side types for the bus request, the control word and the status word
`include "fb_defines.svh"

package wb_pkg;

	// Mode field values of the control word
	localparam logic [1:0] MODE_READ  = 2'b01;    // Stream SRAM into buffers
	localparam logic [1:0] MODE_RESET = 2'b11;    // Send reset sequence

	// ------------------------------------------------------------
	// Host request as seen by the FPGA fabric
	// ------------------------------------------------------------
	typedef struct packed {
		logic [`FB_WB_ADR_W-1:0] adr;    // Word address
		logic [`FB_DATA_W-1:0]   dat;    // Write data
		logic                    we;     // Write enable
		logic                    stb;    // Transfer strobe
		logic                    cyc_ctrl;    // Control and status space
		logic                    cyc_ram;     // Buffer space
	} wb_req_t;

	// Control word written by the host
	typedef struct packed {
		logic [`FB_DATA_W-4:0] rsvd;    // Stored but unused
		logic                  go;      // Hold at bank end while set
		logic [1:0]            mode;    // Sequencer mode
	} fb_ctrl_t;

	// Status word read by the host
	typedef struct packed {
		logic [`FB_DATA_W-5:0] rsvd;         // Reads zero
		logic                  rst_done;     // Reset sequence sent
		logic                  bank_done;    // Bank full, waiting on go
		logic                  rsvd1;        // Reads zero
		logic                  bank;         // Bank being filled
	} fb_status_t;

endpackage

/* qspi_pkg.sv */
// Sequencer side types for the quad-SPI state and the buffer write port
`include "fb_defines.svh"

package qspi_pkg;

	// ------------------------------------------------------------
	// Sequencer states
	// ------------------------------------------------------------
	typedef enum logic [7:0] {
		ST_LOAD   = 8'h00,    // Load read command and burst address
		ST_CMD    = 8'h01,    // Read command bits
		ST_ADDR   = 8'h02,    // Address nibbles
		ST_WAIT   = 8'h03,    // Bus turnaround and dummy cycles
		ST_DATA   = 8'h04,    // Read nibbles
		ST_DESEL  = 8'h05,    // Release nCE after burst
		ST_IDLE   = 8'h06,    // Bank end check
		ST_RCMD0  = 8'h10,    // Reset enable bits
		ST_RGAP   = 8'h11,    // nCE high between reset commands
		ST_RCMD1  = 8'h12,    // Reset bits
		ST_RDESEL = 8'h13,    // Release nCE after reset
		ST_RDONE  = 8'h14,    // Reset sent, hold
		ST_RESET  = 8'hFF     // Entry state
	} qspi_state_e;

	// Buffer write from the sequencer
	typedef struct packed {
		logic                  we;      // One-cycle write pulse
		logic                  bank;    // Target bank
		logic [`FB_ADDR_W-1:0] addr;    // Word address in bank
		logic [`FB_DATA_W-1:0] data;    // Assembled word
	} fb_wr_t;

endpackage

/* frame_ram.sv */
// One 512x32 frame buffer bank written by the sequencer and read by the host
`timescale 1ns/1ps
`include "fb_defines.svh"

module frame_ram (
	input  logic                  WBs_CLK_i,
	input  logic                  we_i,         // Bank-gated write pulse
	input  qspi_pkg::fb_wr_t      wr_i,         // Address and data from sequencer
	input  logic [`FB_ADDR_W-1:0] rd_addr_i,    // Host word address
	output logic [`FB_DATA_W-1:0] rd_dat_o
);

	// ------------------------------------------------------------
	// Storage
	// ------------------------------------------------------------
	logic [`FB_DATA_W-1:0] mem [0:(1 << `FB_ADDR_W)-1];

	// Write port
	always_ff @(posedge WBs_CLK_i) begin
		if (we_i)
			mem[wr_i.addr] <= wr_i.data;
	end

	// Read port with data valid the cycle after the address
	always_ff @(posedge WBs_CLK_i) begin
		rd_dat_o <= mem[rd_addr_i];
	end

endmodule

/* wb_regs.sv */
// Host register block with acknowledge, control register and read data mux
`timescale 1ns/1ps
`include "fb_defines.svh"

module wb_regs (
	input  logic                  WBs_CLK_i,
	input  logic                  WBs_RST_i,
	input  wb_pkg::wb_req_t       wb_req_i,
	input  wb_pkg::fb_status_t    status_i,
	input  logic [`FB_DATA_W-1:0] ram0_dat_i,
	input  logic [`FB_DATA_W-1:0] ram1_dat_i,
	output wb_pkg::fb_ctrl_t      ctrl_o,
	output logic [`FB_DATA_W-1:0] wb_dat_o,
	output logic                  wb_ack_o
);

	// Read source codes
	localparam logic [1:0] SEL_CTRL = 2'd0;
	localparam logic [1:0] SEL_STAT = 2'd1;
	localparam logic [1:0] SEL_RAM0 = 2'd2;
	localparam logic [1:0] SEL_RAM1 = 2'd3;

	logic       ack_nxt;       // Request seen, not yet acknowledged
	logic       ctrl_wr;       // Control register write strobe
	logic [1:0] rd_sel_nxt;    // Source decoded from the request
	logic [1:0] rd_sel_q;      // Source held for the ack cycle

	// ------------------------------------------------------------
	// Decode
	// ------------------------------------------------------------
	assign ack_nxt = wb_req_i.stb & (wb_req_i.cyc_ctrl | wb_req_i.cyc_ram) & ~wb_ack_o;
	assign ctrl_wr = ack_nxt & wb_req_i.cyc_ctrl & wb_req_i.we & ~wb_req_i.adr[0];

	// Bank bit sits just above the word address
	assign rd_sel_nxt = wb_req_i.cyc_ram ? {1'b1, wb_req_i.adr[`FB_ADDR_W]} :
	                                       {1'b0, wb_req_i.adr[0]};

	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			wb_ack_o <= 1'b0;
			ctrl_o   <= '0;          // Idle mode, go clear
			rd_sel_q <= SEL_CTRL;
		end else begin
			wb_ack_o <= ack_nxt;     // One cycle after strobe
			if (ctrl_wr)
				ctrl_o <= wb_req_i.dat;    // Lands in first request cycle
			if (ack_nxt)
				rd_sel_q <= rd_sel_nxt;
		end
	end

	// ------------------------------------------------------------
	// Read data in the ack cycle
	// ------------------------------------------------------------
	always_comb begin
		case (rd_sel_q)
			SEL_CTRL: wb_dat_o = ctrl_o;
			SEL_STAT: wb_dat_o = status_i;
			SEL_RAM0: wb_dat_o = ram0_dat_i;    // Bank read has one cycle latency
			default:  wb_dat_o = ram1_dat_i;
		endcase
	end

endmodule

/* qspi_ctrl.sv */
// Quad-SPI SRAM sequencer for reset commands and bursts into the ping-pong banks
`timescale 1ns/1ps
`include "fb_defines.svh"

module qspi_ctrl (
	input  logic               WBs_CLK_i,
	input  logic               WBs_RST_i,
	input  wb_pkg::fb_ctrl_t   ctrl_i,
	input  logic [3:0]         quad_dat_i,
	output wb_pkg::fb_status_t status_o,
	output qspi_pkg::fb_wr_t   wr_o,
	output logic               quad_nce_o,
	output logic               quad_oe_o,
	output logic [3:0]         quad_dat_o
);

	localparam int BW = $clog2(`QSPI_BURST_WORDS);    // Word index bits in a burst

	qspi_pkg::qspi_state_e   state_q;
	logic [1:0]              mode_q;        // Mode seen last cycle
	logic [7:0]              cmd_sh;        // Command shifter
	logic [`QSPI_ADDR_W-1:0] addr_sh;       // Address shifter
	logic [`QSPI_ADDR_W-1:0] burst_addr;    // Start of current burst
	logic [2:0]              cnt;           // Bit, nibble and cycle count
	logic [`FB_DATA_W-1:0]   data_sh;       // Read data shifter
	logic [`FB_ADDR_W-1:0]   buf_addr;      // Next word in bank
	logic                    bank_q;        // Bank being filled
	logic                    mode_rd;
	logic                    mode_rs;
	logic                    last_word;
	logic                    bank_end;

	assign mode_rd   = (ctrl_i.mode == wb_pkg::MODE_READ);
	assign mode_rs   = (ctrl_i.mode == wb_pkg::MODE_RESET);
	assign last_word = (buf_addr[BW-1:0] == BW'(`QSPI_BURST_WORDS - 1));
	assign bank_end  = (buf_addr == '0);    // Wrapped after four bursts

	always_comb begin
		status_o           = '0;
		status_o.bank      = bank_q;
		status_o.bank_done = (state_q == qspi_pkg::ST_IDLE) && bank_end;
		status_o.rst_done  = (state_q == qspi_pkg::ST_RDONE);
	end

	// ------------------------------------------------------------
	// Sequencer with registered pins
	// ------------------------------------------------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			state_q    <= qspi_pkg::ST_RESET;
			mode_q     <= '0;
			cnt        <= '0;
			buf_addr   <= '0;
			burst_addr <= '0;
			bank_q     <= 1'b0;
			quad_nce_o <= 1'b1;
			quad_oe_o  <= 1'b1;
			quad_dat_o <= '0;
			wr_o.we    <= 1'b0;
		end else begin
			mode_q  <= ctrl_i.mode;
			wr_o.we <= 1'b0;                            // Single cycle pulse
			if ((ctrl_i.mode != mode_q) || !(mode_rd || mode_rs)) begin
				state_q    <= qspi_pkg::ST_RESET;    // Restart on any mode change
				quad_nce_o <= 1'b1;
				quad_oe_o  <= 1'b1;
			end else begin
				case (state_q)
					qspi_pkg::ST_RESET: begin
						cnt        <= '0;
						buf_addr   <= '0;
						burst_addr <= '0;
						bank_q     <= 1'b0;
						quad_nce_o <= 1'b1;
						quad_oe_o  <= 1'b1;
						cmd_sh     <= `QSPI_CMD_RSTEN;    // Used by reset mode only
						state_q    <= mode_rd ? qspi_pkg::ST_LOAD : qspi_pkg::ST_RCMD0;
					end
					qspi_pkg::ST_LOAD: begin
						cmd_sh  <= `QSPI_CMD_READ;
						addr_sh <= burst_addr;
						cnt     <= '0;
						state_q <= qspi_pkg::ST_CMD;
					end
					qspi_pkg::ST_CMD, qspi_pkg::ST_RCMD0, qspi_pkg::ST_RCMD1: begin
						quad_nce_o <= 1'b0;
						quad_dat_o <= {3'b000, cmd_sh[7]};    // MSB first on bit 0
						cmd_sh     <= {cmd_sh[6:0], 1'b0};
						cnt        <= cnt + 3'd1;
						if (cnt == 3'd7) begin
							case (state_q)
								qspi_pkg::ST_CMD:   state_q <= qspi_pkg::ST_ADDR;
								qspi_pkg::ST_RCMD0: state_q <= qspi_pkg::ST_RGAP;
								default:            state_q <= qspi_pkg::ST_RDESEL;
							endcase
						end
					end
					qspi_pkg::ST_ADDR: begin
						quad_dat_o <= addr_sh[`QSPI_ADDR_W-1 -: 4];    // High nibble first
						addr_sh    <= {addr_sh[`QSPI_ADDR_W-5:0], 4'h0};
						cnt        <= cnt + 3'd1;
						if (cnt == 3'd5) begin
							cnt     <= '0;
							state_q <= qspi_pkg::ST_WAIT;
						end
					end
					qspi_pkg::ST_WAIT: begin
						// First cycle still drives the last address nibble on the pins
						quad_oe_o  <= 1'b0;
						quad_dat_o <= '0;
						cnt        <= cnt + 3'd1;
						if (cnt == 3'(`QSPI_WAIT_CYC)) begin
							cnt     <= '0;
							state_q <= qspi_pkg::ST_DATA;
						end
					end
					qspi_pkg::ST_DATA: begin
						data_sh <= {data_sh[`FB_DATA_W-5:0], quad_dat_i};    // MS nibble first
						cnt     <= cnt + 3'd1;                               // Wraps per word
						if (cnt == 3'd7) begin
							wr_o.we   <= 1'b1;
							wr_o.bank <= bank_q;
							wr_o.addr <= buf_addr;
							wr_o.data <= {data_sh[`FB_DATA_W-5:0], quad_dat_i};
							buf_addr  <= buf_addr + 1'b1;
							if (last_word)
								state_q <= qspi_pkg::ST_DESEL;
						end
					end
					qspi_pkg::ST_DESEL: begin
						quad_nce_o <= 1'b1;
						quad_oe_o  <= 1'b1;
						burst_addr <= burst_addr + `QSPI_ADDR_W'(`QSPI_BURST_WORDS * 4);
						state_q    <= qspi_pkg::ST_IDLE;
					end
					qspi_pkg::ST_IDLE: begin
						if (!bank_end) begin
							state_q <= qspi_pkg::ST_LOAD;    // Next burst, same bank
						end else if (!ctrl_i.go) begin
							bank_q  <= ~bank_q;              // Host released the full bank
							state_q <= qspi_pkg::ST_LOAD;
						end
					end
					qspi_pkg::ST_RGAP: begin
						quad_nce_o <= 1'b1;
						cmd_sh     <= `QSPI_CMD_RST;
						state_q    <= qspi_pkg::ST_RCMD1;
					end
					qspi_pkg::ST_RDESEL: begin
						quad_nce_o <= 1'b1;
						state_q    <= qspi_pkg::ST_RDONE;
					end
					qspi_pkg::ST_RDONE: begin
						state_q <= qspi_pkg::ST_RDONE;    // Hold until mode changes
					end
					default: begin
						quad_nce_o <= 1'b1;
						quad_oe_o  <= 1'b1;
						state_q    <= qspi_pkg::ST_RESET;
					end
				endcase
			end
		end
	end

endmodule

/* qspi_frame_top.sv */
// Quad-SPI frame reader top joining host registers, sequencer and two buffer banks
`timescale 1ns/1ps
`include "fb_defines.svh"

module qspi_frame_top (
	input  logic                  WBs_CLK_i,
	input  logic                  WBs_RST_i,
	input  wb_pkg::wb_req_t       wb_req_i,
	input  logic [3:0]            quad_dat_i,
	output logic [`FB_DATA_W-1:0] wb_dat_o,
	output logic                  wb_ack_o,
	output logic                  quad_nce_o,
	output logic                  quad_oe_o,
	output logic [3:0]            quad_dat_o
);

	wb_pkg::fb_ctrl_t      ctrl;        // Host control word
	wb_pkg::fb_status_t    status;      // Sequencer status
	qspi_pkg::fb_wr_t      wr;          // Buffer write from sequencer
	logic [`FB_DATA_W-1:0] ram0_dat;
	logic [`FB_DATA_W-1:0] ram1_dat;
	logic                  bank0_we;
	logic                  bank1_we;

	// Steer the write pulse to the active bank
	assign bank0_we = wr.we & ~wr.bank;
	assign bank1_we = wr.we & wr.bank;

	// ------------------------------------------------------------
	// Instances
	// ------------------------------------------------------------
	wb_regs u_regs (
		.WBs_CLK_i  (WBs_CLK_i),
		.WBs_RST_i  (WBs_RST_i),
		.wb_req_i   (wb_req_i),
		.status_i   (status),
		.ram0_dat_i (ram0_dat),
		.ram1_dat_i (ram1_dat),
		.ctrl_o     (ctrl),
		.wb_dat_o   (wb_dat_o),
		.wb_ack_o   (wb_ack_o)
	);

	qspi_ctrl u_ctrl (
		.WBs_CLK_i  (WBs_CLK_i),
		.WBs_RST_i  (WBs_RST_i),
		.ctrl_i     (ctrl),
		.quad_dat_i (quad_dat_i),
		.status_o   (status),
		.wr_o       (wr),
		.quad_nce_o (quad_nce_o),
		.quad_oe_o  (quad_oe_o),
		.quad_dat_o (quad_dat_o)
	);

	frame_ram u_bank0 (
		.WBs_CLK_i (WBs_CLK_i),
		.we_i      (bank0_we),
		.wr_i      (wr),
		.rd_addr_i (wb_req_i.adr[`FB_ADDR_W-1:0]),
		.rd_dat_o  (ram0_dat)
	);

	frame_ram u_bank1 (
		.WBs_CLK_i (WBs_CLK_i),
		.we_i      (bank1_we),
		.wr_i      (wr),
		.rd_addr_i (wb_req_i.adr[`FB_ADDR_W-1:0]),
		.rd_dat_o  (ram1_dat)
	);

endmodule

/* qspi_frame_sva.sv */
// Protocol assertions on the quad-SPI pins and the host acknowledge
`timescale 1ns/1ps

module qspi_frame_sva (
	input logic             WBs_CLK_i,
	input logic             WBs_RST_i,
	input wb_pkg::fb_ctrl_t ctrl_i,
	input logic             quad_nce_i,
	input logic             quad_oe_i,
	input logic             wb_ack_i
);

	int   sva_err_cnt = 0;    // Failure count
	logic mode_idle;

	assign mode_idle = (ctrl_i.mode != wb_pkg::MODE_READ) && (ctrl_i.mode != wb_pkg::MODE_RESET);

	// ------------------------------------------------------------
	// Pin and handshake rules
	// ------------------------------------------------------------
	oe_fall_selected: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		$fell(quad_oe_i) |-> !quad_nce_i)
		else begin
			$error("quad_oe_o fell while quad_nce_o was high");
			sva_err_cnt++;
		end

	ack_single: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		wb_ack_i |=> !wb_ack_i)
		else begin
			$error("wb_ack_o high for two cycles in a row");
			sva_err_cnt++;
		end

	// Sequencer sees the new mode one cycle late
	idle_released: assert property (@(posedge WBs_CLK_i) disable iff (WBs_RST_i)
		(mode_idle && $past(mode_idle)) |-> (quad_nce_i && quad_oe_i))
		else begin
			$error("quad_nce_o or quad_oe_o low in idle mode");
			sva_err_cnt++;
		end

endmodule

/* tb_qspi_frame.sv */
// Directed testbench for the quad-SPI frame reader with a behavioral SRAM responder
`timescale 1ns/1ps
`include "fb_defines.svh"

module tb_qspi_frame;

	logic                  clk;
	logic                  rst;
	wb_pkg::wb_req_t       req;           // Host request into the DUT
	logic [3:0]            quad_dat_i;    // Driven by the SRAM responder
	logic [`FB_DATA_W-1:0] wb_dat;
	logic                  wb_ack;
	logic                  quad_nce;
	logic                  quad_oe;
	logic [3:0]            quad_dat_o;
	int                    err_cnt;
	int                    wr_cnt;        // Buffer write pulses seen
	logic [7:0]            cmd_q[$];      // Command bytes decoded from the pins
	logic [23:0]           addr_q[$];     // Burst start addresses decoded
	logic [7:0]            rsp_cmd;
	logic [23:0]           rsp_addr;
	logic [31:0]           rsp_word;
	int                    rsp_bits;      // Selected cycles with oe high
	int                    rsp_dly;       // Selected cycles with oe low
	int                    rsp_n;         // Nibble index in the burst

	qspi_frame_top u_dut (
		.WBs_CLK_i  (clk),
		.WBs_RST_i  (rst),
		.wb_req_i   (req),
		.quad_dat_i (quad_dat_i),
		.wb_dat_o   (wb_dat),
		.wb_ack_o   (wb_ack),
		.quad_nce_o (quad_nce),
		.quad_oe_o  (quad_oe),
		.quad_dat_o (quad_dat_o)
	);

	bind qspi_frame_top qspi_frame_sva u_sva (
		.WBs_CLK_i  (WBs_CLK_i),
		.WBs_RST_i  (WBs_RST_i),
		.ctrl_i     (ctrl),
		.quad_nce_i (quad_nce_o),
		.quad_oe_i  (quad_oe_o),
		.wb_ack_i   (wb_ack_o)
	);

	always #5 clk = ~clk;    // 10 ns period

	// SRAM content at byte address a
	function automatic logic [31:0] sram_word(input logic [23:0] a);
		return {8'hA5, 2'b00, a[23:2]};
	endfunction

	// ------------------------------------------------------------
	// SRAM responder observing the pins 1 ns after each edge
	// ------------------------------------------------------------
	always @(posedge clk) begin
		#1;
		if (u_dut.wr.we)
			wr_cnt++;
		if (quad_nce) begin
			if (rsp_bits >= 8)
				cmd_q.push_back(rsp_cmd);      // End of a command
			if (rsp_bits == 14)
				addr_q.push_back(rsp_addr);    // Command plus full address
			rsp_bits = 0;
			rsp_dly  = 0;
		end else if (quad_oe) begin
			if (rsp_bits < 8)
				rsp_cmd = {rsp_cmd[6:0], quad_dat_o[0]};
			else
				rsp_addr = {rsp_addr[19:0], quad_dat_o};
			rsp_bits++;
		end else begin
			rsp_dly++;
			if (rsp_dly > `QSPI_WAIT_CYC) begin    // Past the dummy cycles
				rsp_n      = rsp_dly - `QSPI_WAIT_CYC - 1;
				rsp_word   = sram_word(rsp_addr + 24'(4 * (rsp_n / 8)));
				quad_dat_i = rsp_word[(31 - 4 * (rsp_n % 8)) -: 4];
			end
		end
	end

	task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			err_cnt++;
			$display("ERR %0d ns %s expected 0x%h actual 0x%h", $time, name, exp, act);
		end
	endtask

	task automatic note_failure(input string what);
		err_cnt++;
		$display("Error at %0d ns: %s", $time, what);
	endtask

	// One host access that checks for a single ack one cycle after the request
	task automatic bus_cycle(input logic ram, input logic we, input logic [10:0] adr,
	                         input logic [31:0] dat, output logic [31:0] rdat);
		int cyc;
		req          = '0;
		req.adr      = adr;
		req.dat      = dat;
		req.we       = we;
		req.stb      = 1'b1;
		req.cyc_ctrl = ~ram;
		req.cyc_ram  = ram;
		cyc          = 0;
		do begin
			@(posedge clk);
			#1;
			cyc++;
		end while (!wb_ack && cyc < 20);
		assert (wb_ack) else note_failure("no acknowledge within 20 cycles");
		expect_eq("ack latency", 32'd1, cyc);
		rdat = wb_dat;                   // Valid in the ack cycle
		req  = '0;
		@(posedge clk);
		#1;
		assert (!wb_ack) else note_failure("acknowledge high for a second cycle");
	endtask

	task automatic wb_write(input logic [10:0] adr, input logic [31:0] dat);
		logic [31:0] unused;
		bus_cycle(1'b0, 1'b1, adr, dat, unused);
	endtask

	task automatic wb_read(input logic ram, input logic [10:0] adr, output logic [31:0] rdat);
		bus_cycle(ram, 1'b0, adr, '0, rdat);
	endtask

	// Poll the status word until the masked bits match
	task automatic wait_status(input logic [31:0] mask, input logic [31:0] val, input int limit,
	                           input string what);
		logic [31:0] st;
		int          n;
		n = 0;
		do begin
			wb_read(1'b0, 11'd1, st);
			n++;
		end while ((st & mask) != val && n < limit);
		assert ((st & mask) == val) else note_failure(what);
	endtask

	// Random words of one bank against the SRAM content
	task automatic verify_bank(input logic bank, input logic [23:0] base, input int cnt);
		logic [31:0] rd;
		int unsigned idx;
		for (int k = 0; k < cnt; k++) begin
			idx = $urandom % 512;
			wb_read(1'b1, {1'b0, bank, 9'(idx)}, rd);
			expect_eq($sformatf("bank%0d word %0d", bank, idx),
			          sram_word(base + 24'(idx * 4)), rd);
		end
	endtask

	// ------------------------------------------------------------
	// Behaviors
	// ------------------------------------------------------------
	task automatic after_reset();
		logic [31:0] st;
		expect_eq("wb_ack_o", 32'd0, wb_ack);
		expect_eq("bank0_we", 32'd0, u_dut.bank0_we);
		expect_eq("bank1_we", 32'd0, u_dut.bank1_we);
		expect_eq("quad_nce_o", 32'd1, quad_nce);
		expect_eq("quad_oe_o", 32'd1, quad_oe);
		wb_read(1'b0, 11'd1, st);
		expect_eq("status", 32'd0, st);
	endtask

	task automatic ctrl_readback();
		logic [31:0] rd;
		wb_write(11'd0, 32'hDEAD_BEE8);    // Mode bits idle
		wb_read(1'b0, 11'd0, rd);
		expect_eq("control", 32'hDEAD_BEE8, rd);
		wb_write(11'd0, 32'h0);
	endtask

	task automatic reset_sequence();
		cmd_q.delete();
		wb_write(11'd0, 32'h3);
		wait_status(32'hF, 32'h8, 100, "rst_done never set");
		expect_eq("reset command count", 32'd2, cmd_q.size());
		if (cmd_q.size() == 2) begin
			expect_eq("reset enable command", 32'h66, cmd_q[0]);
			expect_eq("reset command", 32'h99, cmd_q[1]);
		end
	endtask

	task automatic first_bank_fill();
		cmd_q.delete();
		addr_q.delete();
		wb_write(11'd0, 32'h5);    // Read mode with hold at bank end
		wait_status(32'hF, 32'h4, 5000, "bank 0 never reported done");
		expect_eq("burst count", 32'd4, addr_q.size());
		if (addr_q.size() > 0) begin
			expect_eq("first burst address", 32'd0, addr_q[0]);
			expect_eq("read command", 32'hEB, cmd_q[0]);
		end
		verify_bank(1'b0, 24'd0, 16);
	endtask

	task automatic bank_switch();
		wb_write(11'd0, 32'h1);    // Release bank 0
		wait_status(32'h5, 32'h1, 100, "bank bit did not switch to 1");
		wb_write(11'd0, 32'h5);    // Hold again at the end of bank 1
		wait_status(32'hF, 32'h5, 5000, "bank 1 never reported done");
		expect_eq("burst count", 32'd8, addr_q.size());
		if (addr_q.size() > 4)
			expect_eq("bank 1 burst address", 32'd2048, addr_q[4]);
		verify_bank(1'b1, 24'd2048, 16);
		verify_bank(1'b0, 24'd0, 16);
	endtask

	task automatic idle_stop();
		int n;
		int wr_snap;
		wr_snap = wr_cnt;
		n       = 0;
		wb_write(11'd0, 32'h1);    // Start refilling
		while (wr_cnt == wr_snap && n < 200) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (wr_cnt != wr_snap) else note_failure("no buffer write after releasing go");
		wb_write(11'd0, 32'h0);
		n = 0;
		while (!(quad_nce && quad_oe) && n < 20) begin
			@(posedge clk);
			#1;
			n++;
		end
		assert (quad_nce && quad_oe) else note_failure("pins not released in idle mode");
		wr_snap = wr_cnt;
		repeat (100) @(posedge clk);    // Observation window
		#1;
		expect_eq("buffer writes in idle", wr_snap, wr_cnt);
	endtask

	initial begin
		void'($urandom(32'hcd483bc7));
		clk        = 1'b0;
		rst        = 1'b1;
		req        = '0;
		quad_dat_i = '0;
		err_cnt    = 0;
		wr_cnt     = 0;
		rsp_cmd    = '0;
		rsp_addr   = '0;
		rsp_bits   = 0;
		rsp_dly    = 0;
		repeat (10) @(posedge clk);
		#1;
		rst = 1'b0;
		after_reset();
		ctrl_readback();
		reset_sequence();
		first_bank_fill();
		bank_switch();
		idle_stop();
		$display("Errors: %0d check, %0d assertion", err_cnt, u_dut.u_sva.sva_err_cnt);
		if (err_cnt == 0 && u_dut.u_sva.sva_err_cnt == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

/* all.f */
+incdir+.
wb_pkg.sv
qspi_pkg.sv
frame_ram.sv
wb_regs.sv
qspi_ctrl.sv
qspi_frame_top.sv
qspi_frame_sva.sv
tb_qspi_frame.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the quad-SPI frame reader testbench with Verilator
set -euo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_qspi_frame -f all.f -o sim_tb

# Fails unless the simulation reports a pass
./obj_dir/sim_tb | tee /dev/stderr | grep "TEST PASSED" > /dev/null
